//--- fetch_pkg.sv
package fetch_pkg;

    // r view, register-register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // i view, imm12 in the top bits
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // j view, immediate bits still in instruction order
    typedef struct packed {
        logic [19:0] imm_j;      // {imm[20], imm[10:1], imm[11], imm[19:12]}
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_j_t;

    // one fetched word, three ways to read it
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_u;

    typedef enum logic [2:0] {
        KIND_ALU_R = 3'd0,
        KIND_ALU_I = 3'd1,
        KIND_LOAD  = 3'd2,
        KIND_JAL   = 3'd3,
        KIND_OTHER = 3'd4,
        KIND_FAULT = 3'd5
    } kind_e;

    localparam logic [6:0] OP_ALU_R = 7'b0110011;
    localparam logic [6:0] OP_ALU_I = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_JAL   = 7'b1101111;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // instruction | secure | unprivileged
    localparam logic [2:0] PROT_INSTR = 3'b100;

endpackage

//--- pc_gen.sv
`timescale 1ns/1ps

module pc_gen #(
    parameter int              ADDR_WIDTH = 32,
    parameter [ADDR_WIDTH-1:0] RESET_PC   = 'h100
) (
    input  logic                  clock,
    input  logic                  reset,

    // request channel to the bridge
    output logic                  req_valid_o,
    input  logic                  req_ready_i,
    output logic [ADDR_WIDTH-1:0] req_addr_o,
    output logic                  req_epoch_o,

    // jump target from decode
    input  logic                  redirect_valid_i,
    input  logic [ADDR_WIDTH-1:0] redirect_pc_i
);

    logic [ADDR_WIDTH-1:0] pc;
    logic                  epoch;
    logic                  run;      // set one edge after reset release
    logic                  req_fire;

    assign req_fire = req_valid_o && req_ready_i;

    // valid once running, never drops afterwards
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // pc and epoch
    // redirect wins over sequential advance
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc    <= RESET_PC;
            epoch <= 1'b0;
        end else if (redirect_valid_i) begin
            pc    <= redirect_pc_i;
            epoch <= ~epoch;                    // in-flight fetches go stale
        end else if (req_fire) begin
            pc    <= pc + ADDR_WIDTH'(4);       // next word
        end
    end

    // the request may retarget while valid is up,
    // bridge samples only at the handshake
    assign req_valid_o = run;
    assign req_addr_o  = pc;
    assign req_epoch_o = epoch;

endmodule

//--- axi_rd_bridge.sv
`timescale 1ns/1ps

module axi_rd_bridge #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 64
) (
    input  logic                  clock,
    input  logic                  reset,

    // request side, from pc_gen
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  logic [ADDR_WIDTH-1:0] req_addr_i,
    input  logic                  req_epoch_i,

    // response side, to decode
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output logic [DATA_WIDTH-1:0] rsp_data_o,
    output logic [ADDR_WIDTH-1:0] rsp_addr_o,
    output logic                  rsp_epoch_o,
    output logic                  rsp_fault_o,

    // AXI4-Lite read address channel
    input  logic                  axi_ar_ready_i,
    output logic                  axi_ar_valid_o,
    output logic [ADDR_WIDTH-1:0] axi_ar_addr_o,
    output logic [2:0]            axi_ar_prot_o,

    // AXI4-Lite read data channel
    output logic                  axi_r_ready_o,
    input  logic                  axi_r_valid_i,
    input  logic [DATA_WIDTH-1:0] axi_r_data_i,
    input  logic [1:0]            axi_r_resp_i
);

    // read fsm encoding
    localparam logic [1:0] S_IDLE    = 2'b00;
    localparam logic [1:0] S_AR_WAIT = 2'b01;
    localparam logic [1:0] S_R_WAIT  = 2'b11;

    logic [1:0]            state;
    logic [1:0]            state_next;

    logic [ADDR_WIDTH-1:0] addr_q;      // address of the read on the bus
    logic                  epoch_q;     // its epoch tag
    logic                  rsp_full;    // response register occupied

    logic                  req_fire;
    logic                  ar_fire;
    logic                  r_fire;
    logic                  rsp_fire;

    assign req_fire = req_valid_i && req_ready_o;
    assign ar_fire  = axi_ar_valid_o && axi_ar_ready_i;
    assign r_fire   = axi_r_valid_i && axi_r_ready_o;
    assign rsp_fire = rsp_valid_o && rsp_ready_i;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE:    if (req_valid_i) state_next = S_AR_WAIT;
            S_AR_WAIT: if (ar_fire) state_next = S_R_WAIT;
            S_R_WAIT:  if (r_fire) state_next = S_IDLE;    // only when rready given
            default:   state_next = S_IDLE;
        endcase
    end

    // address latched at request time and held through AR
    always_ff @(posedge clock) begin
        if (req_fire) begin
            addr_q  <= req_addr_i;
            epoch_q <= req_epoch_i;
        end
    end

    // occupancy of the one-entry response register
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rsp_full <= 1'b0;
        end else if (r_fire) begin
            rsp_full <= 1'b1;
        end else if (rsp_fire) begin
            rsp_full <= 1'b0;
        end
    end

    // response payload captured with the R beat
    always_ff @(posedge clock) begin
        if (r_fire) begin
            rsp_data_o  <= axi_r_data_i;
            rsp_addr_o  <= addr_q;
            rsp_epoch_o <= epoch_q;
            rsp_fault_o <= (axi_r_resp_i != fetch_pkg::RESP_OKAY);  // slverr / decerr
        end
    end

    assign req_ready_o = (state == S_IDLE);
    assign rsp_valid_o = rsp_full;

    assign axi_ar_valid_o = (state == S_AR_WAIT);
    assign axi_ar_addr_o  = addr_q;
    assign axi_ar_prot_o  = fetch_pkg::PROT_INSTR;
    assign axi_r_ready_o  = (state == S_R_WAIT) && !rsp_full;   // stall R while full

endmodule

//--- fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 64
) (
    input  logic                  clock,
    input  logic                  reset,

    // response from bridge
    input  logic                  rsp_valid_i,
    output logic                  rsp_ready_o,
    input  logic [DATA_WIDTH-1:0] rsp_data_i,
    input  logic [ADDR_WIDTH-1:0] rsp_addr_i,
    input  logic                  rsp_epoch_i,
    input  logic                  rsp_fault_i,

    // jump back to pc_gen
    output logic                  redirect_valid_o,
    output logic [ADDR_WIDTH-1:0] redirect_pc_o,

    // decoded instruction
    output logic                  dec_valid_o,
    input  logic                  dec_ready_i,
    output logic [ADDR_WIDTH-1:0] dec_pc_o,
    output fetch_pkg::kind_e      dec_kind_o,
    output logic [4:0]            dec_rd_o,
    output logic [4:0]            dec_rs1_o,
    output logic [4:0]            dec_rs2_o,
    output logic [ADDR_WIDTH-1:0] dec_imm_o
);

    logic [31:0]           word;
    fetch_pkg::instr_u     ins;
    logic                  exp_epoch;   // epoch expected after the last jump
    logic                  rsp_fire;
    logic                  keep;        // accepted and current

    fetch_pkg::kind_e      kind;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [ADDR_WIDTH-1:0] imm;
    logic [20:0]           jimm;

    // pick the 32-bit half addressed by bit 2
    if (DATA_WIDTH == 64) begin : g_sel64
        assign word = rsp_addr_i[2] ? rsp_data_i[63:32] : rsp_data_i[31:0];
    end else begin : g_sel32
        assign word = rsp_data_i[31:0];
    end

    assign ins = word;

    // unscramble the j-type immediate
    assign jimm = {ins.j.imm_j[19], ins.j.imm_j[7:0], ins.j.imm_j[8],
                   ins.j.imm_j[18:9], 1'b0};

    always_comb begin
        kind = fetch_pkg::KIND_OTHER;
        rd   = ins.i.rd;
        rs1  = ins.i.rs1;
        rs2  = 5'd0;
        imm  = ADDR_WIDTH'(ins.i.imm12);     // raw imm12 for unknown opcodes
        if (rsp_fault_i) begin
            kind = fetch_pkg::KIND_FAULT;    // bad read, nothing to decode
            rd   = 5'd0;
            rs1  = 5'd0;
            imm  = '0;
        end else begin
            case (ins.r.opcode)
                fetch_pkg::OP_ALU_R: begin
                    kind = fetch_pkg::KIND_ALU_R;
                    rd   = ins.r.rd;
                    rs1  = ins.r.rs1;
                    rs2  = ins.r.rs2;
                    imm  = '0;
                end
                fetch_pkg::OP_ALU_I, fetch_pkg::OP_LOAD: begin
                    kind = (ins.i.opcode == fetch_pkg::OP_LOAD) ? fetch_pkg::KIND_LOAD
                                                                : fetch_pkg::KIND_ALU_I;
                    imm  = {{(ADDR_WIDTH-12){ins.i.imm12[11]}}, ins.i.imm12};
                end
                fetch_pkg::OP_JAL: begin
                    kind = fetch_pkg::KIND_JAL;
                    rd   = ins.j.rd;
                    rs1  = 5'd0;
                    imm  = {{(ADDR_WIDTH-21){jimm[20]}}, jimm};
                end
                default: ;                   // other, i-view fields as they are
            endcase
        end
    end

    // take a response whenever the output slot is free or draining
    assign rsp_ready_o = !dec_valid_o || dec_ready_i;
    assign rsp_fire    = rsp_valid_i && rsp_ready_o;
    assign keep        = rsp_fire && (rsp_epoch_i == exp_epoch);  // stale ones drop here

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            dec_valid_o      <= 1'b0;
            redirect_valid_o <= 1'b0;
            exp_epoch        <= 1'b0;
        end else begin
            redirect_valid_o <= 1'b0;        // single-cycle pulse
            if (keep) begin
                dec_valid_o <= 1'b1;
                if (kind == fetch_pkg::KIND_JAL) begin
                    redirect_valid_o <= 1'b1;
                    exp_epoch        <= ~exp_epoch;
                end
            end else if (dec_ready_i) begin
                dec_valid_o <= 1'b0;
            end
        end
    end

    // output payload and jump target
    always_ff @(posedge clock) begin
        if (keep) begin
            dec_pc_o      <= rsp_addr_i;
            dec_kind_o    <= kind;
            dec_rd_o      <= rd;
            dec_rs1_o     <= rs1;
            dec_rs2_o     <= rs2;
            dec_imm_o     <= imm;
            redirect_pc_o <= rsp_addr_i + imm;   // used only with the pulse
        end
    end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int              ADDR_WIDTH = 32,
    parameter int              DATA_WIDTH = 64,
    parameter [ADDR_WIDTH-1:0] RESET_PC   = 'h100
) (
    input  logic                  clock,
    input  logic                  reset,

    // AXI4-Lite read master
    input  logic                  axi_ar_ready_i,
    output logic                  axi_ar_valid_o,
    output logic [ADDR_WIDTH-1:0] axi_ar_addr_o,
    output logic [2:0]            axi_ar_prot_o,
    output logic                  axi_r_ready_o,
    input  logic                  axi_r_valid_i,
    input  logic [DATA_WIDTH-1:0] axi_r_data_i,
    input  logic [1:0]            axi_r_resp_i,

    // decoded stream
    output logic                  dec_valid_o,
    input  logic                  dec_ready_i,
    output logic [ADDR_WIDTH-1:0] dec_pc_o,
    output fetch_pkg::kind_e      dec_kind_o,
    output logic [4:0]            dec_rd_o,
    output logic [4:0]            dec_rs1_o,
    output logic [4:0]            dec_rs2_o,
    output logic [ADDR_WIDTH-1:0] dec_imm_o
);

    // pc_gen -> bridge
    logic                  req_valid;
    logic                  req_ready;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic                  req_epoch;

    // bridge -> decode
    logic                  rsp_valid;
    logic                  rsp_ready;
    logic [DATA_WIDTH-1:0] rsp_data;
    logic [ADDR_WIDTH-1:0] rsp_addr;
    logic                  rsp_epoch;
    logic                  rsp_fault;

    // decode -> pc_gen
    logic                  redirect_valid;
    logic [ADDR_WIDTH-1:0] redirect_pc;

    pc_gen #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .RESET_PC   (RESET_PC)
    ) u_pc_gen (
        .clock            (clock),
        .reset            (reset),
        .req_valid_o      (req_valid),
        .req_ready_i      (req_ready),
        .req_addr_o       (req_addr),
        .req_epoch_o      (req_epoch),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc)
    );

    axi_rd_bridge #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_axi_rd_bridge (
        .clock          (clock),
        .reset          (reset),
        .req_valid_i    (req_valid),
        .req_ready_o    (req_ready),
        .req_addr_i     (req_addr),
        .req_epoch_i    (req_epoch),
        .rsp_valid_o    (rsp_valid),
        .rsp_ready_i    (rsp_ready),
        .rsp_data_o     (rsp_data),
        .rsp_addr_o     (rsp_addr),
        .rsp_epoch_o    (rsp_epoch),
        .rsp_fault_o    (rsp_fault),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_addr_o  (axi_ar_addr_o),
        .axi_ar_prot_o  (axi_ar_prot_o),
        .axi_r_ready_o  (axi_r_ready_o),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_data_i   (axi_r_data_i),
        .axi_r_resp_i   (axi_r_resp_i)
    );

    fetch_decode #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_fetch_decode (
        .clock            (clock),
        .reset            (reset),
        .rsp_valid_i      (rsp_valid),
        .rsp_ready_o      (rsp_ready),
        .rsp_data_i       (rsp_data),
        .rsp_addr_i       (rsp_addr),
        .rsp_epoch_i      (rsp_epoch),
        .rsp_fault_i      (rsp_fault),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .dec_valid_o      (dec_valid_o),
        .dec_ready_i      (dec_ready_i),
        .dec_pc_o         (dec_pc_o),
        .dec_kind_o       (dec_kind_o),
        .dec_rd_o         (dec_rd_o),
        .dec_rs1_o        (dec_rs1_o),
        .dec_rs2_o        (dec_rs2_o),
        .dec_imm_o        (dec_imm_o)
    );

endmodule

//--- tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem (
    input  logic        clock,
    input  logic        reset,
    input  logic        ar_valid_i,
    output logic        ar_ready_o,
    input  logic [31:0] ar_addr_i,
    output logic        r_valid_o,
    input  logic        r_ready_i,
    output logic [63:0] r_data_o,
    output logic [1:0]  r_resp_o
);

    logic [31:0] mem [0:127];       // 0x000..0x1ff, written by the testbench
    logic [31:0] rnd;
    logic [1:0]  wait_cnt;          // cycles left before ready / valid
    logic        busy;              // between AR and R handshakes
    logic [31:0] addr_q;
    logic        ar_hs;
    logic        r_hs;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // handshakes seen on the rising edge, used on the next falling edge
    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            ar_hs <= 1'b0;
            r_hs  <= 1'b0;
        end else begin
            ar_hs <= ar_valid_i && ar_ready_o;
            r_hs  <= r_valid_o && r_ready_i;
        end
    end

    // slave outputs change on the falling edge only
    always @(negedge clock or negedge reset) begin
        if (!reset) begin
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            r_data_o   <= '0;
            r_resp_o   <= 2'b00;
            busy       <= 1'b0;
            wait_cnt   <= 2'd0;
            addr_q     <= '0;
            rnd        <= 32'h6846;
        end else if (!busy) begin
            if (ar_ready_o) begin
                if (ar_hs) begin
                    ar_ready_o <= 1'b0;
                    busy       <= 1'b1;
                    wait_cnt   <= rnd[3:2];     // data delay
                    rnd        <= xorshift32(rnd);
                end
            end else if (ar_valid_i) begin
                if (wait_cnt == 2'd0) begin
                    ar_ready_o <= 1'b1;
                    addr_q     <= ar_addr_i;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end else begin
            if (r_valid_o) begin
                if (r_hs) begin
                    r_valid_o <= 1'b0;
                    busy      <= 1'b0;
                    wait_cnt  <= rnd[1:0];      // next address delay
                    rnd       <= xorshift32(rnd);
                end
            end else if (wait_cnt == 2'd0) begin
                r_valid_o <= 1'b1;
                r_data_o  <= {mem[{addr_q[8:3], 1'b1}], mem[{addr_q[8:3], 1'b0}]};
                r_resp_o  <= (addr_q >= 32'h200) ? 2'b10 : 2'b00;  // slverr region
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

//--- tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

    localparam int          ROWS     = 12;
    localparam int          LIMIT    = ROWS * 20 + 50;
    localparam logic [31:0] RESET_PC = 32'h100;

    logic        clock;
    logic        reset;
    logic        dec_ready_i;
    logic        ar_ready;
    logic        ar_valid;
    logic [31:0] ar_addr;
    logic [2:0]  ar_prot;
    logic        r_ready;
    logic        r_valid;
    logic [63:0] r_data;
    logic [1:0]  r_resp;
    logic        dec_valid_o;
    logic [31:0] dec_pc_o;
    fetch_pkg::kind_e dec_kind_o;
    logic [4:0]  dec_rd_o;
    logic [4:0]  dec_rs1_o;
    logic [4:0]  dec_rs2_o;
    logic [31:0] dec_imm_o;

    // program and expected decode per output instruction
    logic [31:0] row_addr [ROWS];
    logic [31:0] row_word [ROWS];
    logic [2:0]  row_kind [ROWS];
    logic [4:0]  row_rd   [ROWS];
    logic [4:0]  row_rs1  [ROWS];
    logic [4:0]  row_rs2  [ROWS];
    logic [31:0] row_imm  [ROWS];

    logic [31:0] rnd;
    int          row;
    int          cycles;

    fetch_top #(
        .ADDR_WIDTH (32),
        .DATA_WIDTH (64),
        .RESET_PC   (RESET_PC)
    ) u_dut (
        .clock          (clock),
        .reset          (reset),
        .axi_ar_ready_i (ar_ready),
        .axi_ar_valid_o (ar_valid),
        .axi_ar_addr_o  (ar_addr),
        .axi_ar_prot_o  (ar_prot),
        .axi_r_ready_o  (r_ready),
        .axi_r_valid_i  (r_valid),
        .axi_r_data_i   (r_data),
        .axi_r_resp_i   (r_resp),
        .dec_valid_o    (dec_valid_o),
        .dec_ready_i    (dec_ready_i),
        .dec_pc_o       (dec_pc_o),
        .dec_kind_o     (dec_kind_o),
        .dec_rd_o       (dec_rd_o),
        .dec_rs1_o      (dec_rs1_o),
        .dec_rs2_o      (dec_rs2_o),
        .dec_imm_o      (dec_imm_o)
    );

    tb_axi_mem u_mem (
        .clock      (clock),
        .reset      (reset),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .ar_addr_i  (ar_addr),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .r_data_o   (r_data),
        .r_resp_o   (r_resp)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("CHECK FAILED %s got %h expected %h (row %0d)", name, got, exp, row);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic add_row(input int i, input logic [31:0] addr, input logic [31:0] word,
                           input logic [2:0] kind, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [31:0] imm);
        row_addr[i] = addr;
        row_word[i] = word;
        row_kind[i] = kind;
        row_rd[i]   = rd;
        row_rs1[i]  = rs1;
        row_rs2[i]  = rs2;
        row_imm[i]  = imm;
    endtask

    task automatic load_program();
        logic [31:0] a;
        // address-dependent filler that must never reach the output
        for (int k = 0; k < 128; k++) begin
            a = k * 4;
            u_mem.mem[k] = (a * 32'h9e3779b1) ^ 32'ha5a5_0000;
        end
        add_row(0,  32'h100, 32'h002081b3, fetch_pkg::KIND_ALU_R, 5'd3, 5'd1, 5'd2, 32'h0);
        add_row(1,  32'h104, 32'hfff30293, fetch_pkg::KIND_ALU_I, 5'd5, 5'd6, 5'd0, 32'hffffffff);
        add_row(2,  32'h108, 32'h00812383, fetch_pkg::KIND_LOAD,  5'd7, 5'd2, 5'd0, 32'h8);
        add_row(3,  32'h10c, 32'h014000ef, fetch_pkg::KIND_JAL,   5'd1, 5'd0, 5'd0, 32'h14);
        add_row(4,  32'h120, 32'h12345537, fetch_pkg::KIND_OTHER, 5'd10, 5'd8, 5'd0, 32'h123);
        add_row(5,  32'h124, 32'h01c0006f, fetch_pkg::KIND_JAL,   5'd0, 5'd0, 5'd0, 32'h1c);
        add_row(6,  32'h140, 32'h00520213, fetch_pkg::KIND_ALU_I, 5'd4, 5'd4, 5'd0, 32'h5);
        add_row(7,  32'h144, 32'hfe5ff16f, fetch_pkg::KIND_JAL,   5'd2, 5'd0, 5'd0, 32'hffffffe4);
        add_row(8,  32'h128, 32'h80000593, fetch_pkg::KIND_ALU_I, 5'd11, 5'd0, 5'd0, 32'hfffff800);
        add_row(9,  32'h12c, 32'h0d40006f, fetch_pkg::KIND_JAL,   5'd0, 5'd0, 5'd0, 32'hd4);
        // fetch runs on sequentially inside the error region
        add_row(10, 32'h200, 32'h0, fetch_pkg::KIND_FAULT, 5'd0, 5'd0, 5'd0, 32'h0);
        add_row(11, 32'h204, 32'h0, fetch_pkg::KIND_FAULT, 5'd0, 5'd0, 5'd0, 32'h0);
        for (int k = 0; k < ROWS; k++) begin
            if (row_addr[k] < 32'h200) begin
                u_mem.mem[row_addr[k][8:2]] = row_word[k];
            end
        end
    endtask

    task automatic check_row(input int i);
        assert (dec_pc_o == row_addr[i]) else value_error("dec_pc_o", dec_pc_o, row_addr[i]);
        assert (dec_kind_o == row_kind[i])
            else value_error("dec_kind_o", {29'd0, dec_kind_o}, {29'd0, row_kind[i]});
        assert (dec_rd_o == row_rd[i])
            else value_error("dec_rd_o", {27'd0, dec_rd_o}, {27'd0, row_rd[i]});
        assert (dec_rs1_o == row_rs1[i])
            else value_error("dec_rs1_o", {27'd0, dec_rs1_o}, {27'd0, row_rs1[i]});
        assert (dec_rs2_o == row_rs2[i])
            else value_error("dec_rs2_o", {27'd0, dec_rs2_o}, {27'd0, row_rs2[i]});
        assert (dec_imm_o == row_imm[i]) else value_error("dec_imm_o", dec_imm_o, row_imm[i]);
    endtask

    // idle bus and empty output while held in reset
    task automatic check_idle();
        assert (!ar_valid) else stop_run("arvalid high during reset");
        assert (!r_ready) else stop_run("rready high during reset");
        assert (!dec_valid_o) else stop_run("dec_valid_o high during reset");
    endtask

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            stop_run($sformatf("timeout, decoded stream stalled at row %0d", row));
        end
    end

    initial begin
        reset       = 1'b0;
        dec_ready_i = 1'b0;
        rnd         = 32'h6846;
        row         = 0;
        cycles      = 0;
        load_program();
        repeat (2) @(posedge clock);
        @(negedge clock);
        check_idle();
        reset = 1'b1;
        while (row < ROWS) begin
            @(negedge clock);
            rnd         = xorshift32(rnd);
            dec_ready_i = (rnd[1:0] != 2'b00);   // ready about 3 cycles in 4
            if (ar_valid) begin
                assert (ar_prot == 3'b100)
                    else value_error("axi_ar_prot_o", {29'd0, ar_prot}, 32'h4);
            end
            if (dec_valid_o && dec_ready_i) begin
                check_row(row);                  // handshake on the next rising edge
                row = row + 1;
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- sources.f
fetch_pkg.sv
pc_gen.sv
axi_rd_bridge.sv
fetch_decode.sv
fetch_top.sv
tb_axi_mem.sv
tb_fetch.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module tb_fetch -Mdir obj_dir

run: compile
	./obj_dir/Vtb_fetch | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
